// File: include/sched_config.svh
// Scheduler core configuration
// Station geometry, tag and data widths, and the 3-bit operation codes
`ifndef SCHED_CONFIG_SVH
`define SCHED_CONFIG_SVH

// Station and datapath sizes
`define RS_SIZE 8
`define TAG_W   6
`define DATA_W  16

// Operation codes, low 3 bits of the opcode field
`define OP_ADD 3'd0
`define OP_SUB 3'd1
`define OP_AND 3'd2
`define OP_OR  3'd3
`define OP_XOR 3'd4
`define OP_SHL 3'd5
`define OP_MUL 3'd6

`endif

// File: source/sched_pkg.sv
// Scheduler core types
// Instruction word views, unit class and ALU operation encodings
`include "sched_config.svh"

package sched_pkg;

	// Register form, three 4-bit register fields
	typedef struct packed {
		logic [3:0] opcode;
		logic [3:0] rd;
		logic [3:0] rs1;
		logic [3:0] rs2;
	} reg_form_t;

	// Immediate form, the low byte is a signed immediate
	// Source 1 arrives by tag, so its field gives way to the immediate
	typedef struct packed {
		logic [3:0] opcode;
		logic [3:0] rd;
		logic [7:0] imm;
	} imm_form_t;

	// Opcode bit 3 picks the view
	typedef union packed {
		reg_form_t reg_form;
		imm_form_t imm_form;
	} inst_word_u;

	typedef enum logic {
		FU_ALU  = 1'b0,
		FU_MULT = 1'b1
	} fu_class_e;

	typedef enum logic [2:0] {
		ALU_ADD = `OP_ADD,
		ALU_SUB = `OP_SUB,
		ALU_AND = `OP_AND,
		ALU_OR  = `OP_OR,
		ALU_XOR = `OP_XOR,
		ALU_SHL = `OP_SHL
	} alu_op_e;

endpackage

// File: source/inst_decode.sv
// Decode stage
// Registers one dispatched instruction and splits the word into class, op, operand 2
`include "sched_config.svh"

module inst_decode import sched_pkg::*; (
	input  logic               clock,
	input  logic               reset,
	input  logic               dispatch_valid,
	input  inst_word_u         inst_word,
	input  logic [`TAG_W-1:0]  dest_tag,
	input  logic [`TAG_W-1:0]  src1_tag,
	input  logic [`TAG_W-1:0]  src2_tag,
	input  logic               src1_ready,
	input  logic               src2_ready,
	input  logic [`DATA_W-1:0] src1_value,
	input  logic [`DATA_W-1:0] src2_value,
	output logic               dec_valid,
	output fu_class_e          dec_class,
	output alu_op_e            dec_op,
	output logic [`TAG_W-1:0]  dec_dest,
	output logic [`TAG_W-1:0]  dec_t1,
	output logic [`TAG_W-1:0]  dec_t2,
	output logic               dec_r1,
	output logic               dec_r2,
	output logic [`DATA_W-1:0] dec_v1,
	output logic [`DATA_W-1:0] dec_v2
);

	localparam logic [2:0] RSVD_CODE = 3'd7;

	logic [3:0]         opcode;
	logic [2:0]         op_code;
	logic               is_imm;
	logic               reserved;
	logic [`DATA_W-1:0] imm_ext;

	// Opcode sits in the same place in both views
	assign opcode   = inst_word.reg_form.opcode;
	assign op_code  = opcode[2:0];
	assign is_imm   = opcode[3];
	assign reserved = (op_code == RSVD_CODE);

	// Sign extend the low byte
	assign imm_ext = {{(`DATA_W-8){inst_word.imm_form.imm[7]}}, inst_word.imm_form.imm};

	always_ff @(posedge clock) begin
		if (reset) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= dispatch_valid & ~reserved;
		end
	end

	// Payload registers follow every dispatch
	always_ff @(posedge clock) begin
		if (dispatch_valid) begin
			dec_class <= (op_code == `OP_MUL) ? FU_MULT : FU_ALU;
			// Multiply ignores the ALU op
			dec_op    <= (op_code == `OP_MUL) ? ALU_ADD : alu_op_e'(op_code);
			dec_dest  <= dest_tag;
			dec_t1    <= src1_tag;
			dec_r1    <= src1_ready;
			dec_v1    <= src1_value;
			dec_t2    <= src2_tag;
			// Immediate form makes source 2 ready at once
			dec_r2    <= is_imm | src2_ready;
			dec_v2    <= is_imm ? imm_ext : src2_value;
		end
	end

	// Reserved code never reaches the station under a valid strobe
	a_no_reserved: assert property (@(posedge clock) disable iff (reset)
		dec_valid |-> (dec_op != alu_op_e'(RSVD_CODE)));

endmodule

// File: source/rs_wakeup_cam.sv
// Wakeup CAM
// Bus tag against both source tags of every station row, in parallel
`include "sched_config.svh"

module rs_wakeup_cam (
	input  logic                cdb_valid,
	input  logic [`TAG_W-1:0]   cdb_tag,
	input  logic [`TAG_W-1:0]   row_t1 [`RS_SIZE],
	input  logic [`TAG_W-1:0]   row_t2 [`RS_SIZE],
	output logic [`RS_SIZE-1:0] t1_hit,
	output logic [`RS_SIZE-1:0] t2_hit
);

	always_comb begin
		t1_hit = '0;
		t2_hit = '0;
		// No broadcast, no hits
		if (cdb_valid) begin
			for (int i = 0; i < `RS_SIZE; i++) begin
				t1_hit[i] = (row_t1[i] == cdb_tag);
				t2_hit[i] = (row_t2[i] == cdb_tag);
			end
		end
	end

endmodule

// File: source/rs_station.sv
// Reservation station
// Row allocation, bus value capture, per-class priority select and issue
`include "sched_config.svh"

module rs_station import sched_pkg::*; (
	input  logic               clock,
	input  logic               reset,
	input  logic               dec_valid,
	input  fu_class_e          dec_class,
	input  alu_op_e            dec_op,
	input  logic [`TAG_W-1:0]  dec_dest,
	input  logic [`TAG_W-1:0]  dec_t1,
	input  logic [`TAG_W-1:0]  dec_t2,
	input  logic               dec_r1,
	input  logic               dec_r2,
	input  logic [`DATA_W-1:0] dec_v1,
	input  logic [`DATA_W-1:0] dec_v2,
	input  logic               cdb_valid,
	input  logic [`TAG_W-1:0]  cdb_tag,
	input  logic [`DATA_W-1:0] cdb_value,
	input  logic               alu_hold,
	output logic               alu_issue,
	output alu_op_e            alu_op,
	output logic [`DATA_W-1:0] alu_a,
	output logic [`DATA_W-1:0] alu_b,
	output logic [`TAG_W-1:0]  alu_tag,
	output logic               mul_issue,
	output logic [`DATA_W-1:0] mul_a,
	output logic [`DATA_W-1:0] mul_b,
	output logic [`TAG_W-1:0]  mul_tag,
	output logic               rs_full,
	output logic               dispatch_drop
);

	// Highest-numbered request wins
	function automatic logic [`RS_SIZE-1:0] pick_high(input logic [`RS_SIZE-1:0] req);
		logic [`RS_SIZE-1:0] gnt;
		logic                found;
		gnt   = '0;
		found = 1'b0;
		for (int i = `RS_SIZE - 1; i >= 0; i--) begin
			if (req[i] && !found) begin
				gnt[i] = 1'b1;
				found  = 1'b1;
			end
		end
		return gnt;
	endfunction

	// Row table
	logic [`RS_SIZE-1:0] row_busy;
	fu_class_e           row_class [`RS_SIZE];
	alu_op_e             row_op    [`RS_SIZE];
	logic [`TAG_W-1:0]   row_dest  [`RS_SIZE];
	logic [`TAG_W-1:0]   row_t1    [`RS_SIZE];
	logic [`TAG_W-1:0]   row_t2    [`RS_SIZE];
	logic [`RS_SIZE-1:0] row_r1;
	logic [`RS_SIZE-1:0] row_r2;
	logic [`DATA_W-1:0]  row_v1    [`RS_SIZE];
	logic [`DATA_W-1:0]  row_v2    [`RS_SIZE];

	logic [`RS_SIZE-1:0] t1_hit;
	logic [`RS_SIZE-1:0] t2_hit;
	logic [`RS_SIZE-1:0] alu_ready;
	logic [`RS_SIZE-1:0] mul_ready;
	logic [`RS_SIZE-1:0] alu_gnt;
	logic [`RS_SIZE-1:0] mul_gnt;
	logic [`RS_SIZE-1:0] alloc_gnt;
	logic                d1_hit;
	logic                d2_hit;

	rs_wakeup_cam u_cam (
		.cdb_valid (cdb_valid),
		.cdb_tag   (cdb_tag),
		.row_t1    (row_t1),
		.row_t2    (row_t2),
		.t1_hit    (t1_hit),
		.t2_hit    (t2_hit)
	);

	// ------------------------------------------------------------
	// Select
	// ------------------------------------------------------------

	// Ready counts from the registered bits only
	always_comb begin
		for (int i = 0; i < `RS_SIZE; i++) begin
			alu_ready[i] = row_busy[i] & row_r1[i] & row_r2[i] & (row_class[i] == FU_ALU);
			mul_ready[i] = row_busy[i] & row_r1[i] & row_r2[i] & (row_class[i] == FU_MULT);
		end
	end

	// ALU issue stalls while the result stage holds an ALU result
	assign alu_gnt   = alu_hold ? '0 : pick_high(alu_ready);
	assign mul_gnt   = pick_high(mul_ready);
	assign alloc_gnt = dec_valid ? pick_high(~row_busy) : '0;

	assign rs_full       = &row_busy;
	assign dispatch_drop = dec_valid & rs_full;

	assign alu_issue = |alu_gnt;
	assign mul_issue = |mul_gnt;

	// Grant muxes
	always_comb begin
		alu_op  = ALU_ADD;
		alu_a   = '0;
		alu_b   = '0;
		alu_tag = '0;
		mul_a   = '0;
		mul_b   = '0;
		mul_tag = '0;
		for (int i = 0; i < `RS_SIZE; i++) begin
			if (alu_gnt[i]) begin
				alu_op  = row_op[i];
				alu_a   = row_v1[i];
				alu_b   = row_v2[i];
				alu_tag = row_dest[i];
			end
			if (mul_gnt[i]) begin
				mul_a   = row_v1[i];
				mul_b   = row_v2[i];
				mul_tag = row_dest[i];
			end
		end
	end

	// ------------------------------------------------------------
	// Table update
	// ------------------------------------------------------------

	// Source waking on the bus in the dispatch cycle
	assign d1_hit = cdb_valid & ~dec_r1 & (dec_t1 == cdb_tag);
	assign d2_hit = cdb_valid & ~dec_r2 & (dec_t2 == cdb_tag);

	always_ff @(posedge clock) begin
		if (reset) begin
			row_busy <= '0;
		end else begin
			// Issued rows free up and allocation only hits idle rows
			row_busy <= (row_busy & ~alu_gnt & ~mul_gnt) | alloc_gnt;
		end
	end

	always_ff @(posedge clock) begin
		for (int i = 0; i < `RS_SIZE; i++) begin
			if (alloc_gnt[i]) begin
				row_class[i] <= dec_class;
				row_op[i]    <= dec_op;
				row_dest[i]  <= dec_dest;
				row_t1[i]    <= dec_t1;
				row_t2[i]    <= dec_t2;
				row_r1[i]    <= dec_r1 | d1_hit;
				row_r2[i]    <= dec_r2 | d2_hit;
				row_v1[i]    <= d1_hit ? cdb_value : dec_v1;
				row_v2[i]    <= d2_hit ? cdb_value : dec_v2;
			end else if (row_busy[i]) begin
				// Capture on a hit but never over a value already held
				if (t1_hit[i] && !row_r1[i]) begin
					row_r1[i] <= 1'b1;
					row_v1[i] <= cdb_value;
				end
				if (t2_hit[i] && !row_r2[i]) begin
					row_r2[i] <= 1'b1;
					row_v2[i] <= cdb_value;
				end
			end
		end
	end

	// ------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------
	a_one_grant: assert property (@(posedge clock) disable iff (reset)
		$onehot0(alu_gnt) && $onehot0(mul_gnt));

	a_issue_ready: assert property (@(posedge clock) disable iff (reset)
		(alu_issue || mul_issue) |->
			(((alu_gnt | mul_gnt) & ~(row_busy & row_r1 & row_r2)) == '0));

	// Ready ALU rows stay seated across a hold cycle
	a_hold_stall: assert property (@(posedge clock) disable iff (reset)
		alu_hold |=> (($past(alu_ready) & ~row_busy) == '0));

endmodule

// File: source/fu_execute.sv
// Functional units
// Single-cycle registered ALU and a two-stage multiply pipeline
`include "sched_config.svh"

module fu_execute import sched_pkg::*; (
	input  logic               clock,
	input  logic               reset,
	input  logic               alu_issue,
	input  alu_op_e            alu_op,
	input  logic [`DATA_W-1:0] alu_a,
	input  logic [`DATA_W-1:0] alu_b,
	input  logic [`TAG_W-1:0]  alu_tag,
	input  logic               mul_issue,
	input  logic [`DATA_W-1:0] mul_a,
	input  logic [`DATA_W-1:0] mul_b,
	input  logic [`TAG_W-1:0]  mul_tag,
	output logic               alu_done,
	output logic [`DATA_W-1:0] alu_result,
	output logic [`TAG_W-1:0]  alu_rtag,
	output logic               mul_done,
	output logic [`DATA_W-1:0] mul_result,
	output logic [`TAG_W-1:0]  mul_rtag
);

	logic [`DATA_W-1:0]   alu_next;
	logic                 m1_valid;
	logic [`DATA_W-1:0]   m1_a;
	logic [`DATA_W-1:0]   m1_b;
	logic [`TAG_W-1:0]    m1_tag;
	logic [2*`DATA_W-1:0] m1_prod;

	// ALU, shift amount from the low 4 bits
	always_comb begin
		case (alu_op)
			ALU_ADD: alu_next = alu_a + alu_b;
			ALU_SUB: alu_next = alu_a - alu_b;
			ALU_AND: alu_next = alu_a & alu_b;
			ALU_OR:  alu_next = alu_a | alu_b;
			ALU_XOR: alu_next = alu_a ^ alu_b;
			ALU_SHL: alu_next = alu_a << alu_b[3:0];
			default: alu_next = '0;
		endcase
	end

	// Full product, only the low half is kept
	assign m1_prod = m1_a * m1_b;

	// Strobes
	always_ff @(posedge clock) begin
		if (reset) begin
			alu_done <= 1'b0;
			m1_valid <= 1'b0;
			mul_done <= 1'b0;
		end else begin
			alu_done <= alu_issue;
			m1_valid <= mul_issue;
			mul_done <= m1_valid;
		end
	end

	// Datapath registers
	always_ff @(posedge clock) begin
		alu_result <= alu_next;
		alu_rtag   <= alu_tag;
		// Stage 1 holds the operands
		m1_a       <= mul_a;
		m1_b       <= mul_b;
		m1_tag     <= mul_tag;
		// Stage 2 holds the product
		mul_result <= m1_prod[`DATA_W-1:0];
		mul_rtag   <= m1_tag;
	end

endmodule

// File: source/cdb_result.sv
// Result stage
// Merges both units onto the common data bus, multiply first, ALU parked on collision
`include "sched_config.svh"

module cdb_result (
	input  logic               clock,
	input  logic               reset,
	input  logic               alu_done,
	input  logic [`DATA_W-1:0] alu_result,
	input  logic [`TAG_W-1:0]  alu_rtag,
	input  logic               mul_done,
	input  logic [`DATA_W-1:0] mul_result,
	input  logic [`TAG_W-1:0]  mul_rtag,
	output logic               cdb_valid,
	output logic [`TAG_W-1:0]  cdb_tag,
	output logic [`DATA_W-1:0] cdb_value,
	output logic               alu_hold
);

	logic               hold_valid;
	logic [`DATA_W-1:0] hold_value;
	logic [`TAG_W-1:0]  hold_tag;
	logic               collide;

	assign collide = alu_done & mul_done;

	// Level also rises in the collision cycle, so no ALU result lands on a full register
	assign alu_hold = hold_valid | collide;

	// Multiply, then held ALU, then fresh ALU
	always_comb begin
		cdb_valid = 1'b0;
		cdb_tag   = alu_rtag;
		cdb_value = alu_result;
		if (mul_done) begin
			cdb_valid = 1'b1;
			cdb_tag   = mul_rtag;
			cdb_value = mul_result;
		end else if (hold_valid) begin
			cdb_valid = 1'b1;
			cdb_tag   = hold_tag;
			cdb_value = hold_value;
		end else if (alu_done) begin
			cdb_valid = 1'b1;
		end
	end

	// Empties on the first cycle without a multiply
	always_ff @(posedge clock) begin
		if (reset) begin
			hold_valid <= 1'b0;
		end else if (collide) begin
			hold_valid <= 1'b1;
		end else if (!mul_done) begin
			hold_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (collide) begin
			hold_value <= alu_result;
			hold_tag   <= alu_rtag;
		end
	end

	// Held result is never overwritten by a new ALU completion
	a_hold_safe: assert property (@(posedge clock) disable iff (reset)
		hold_valid |-> !alu_done);

endmodule

// File: source/sched_core_top.sv
// Scheduler core top
// Decode, reservation station, functional units and result bus
`include "sched_config.svh"

module sched_core_top import sched_pkg::*; (
	input  logic               clock,
	input  logic               reset,
	input  logic               dispatch_valid,
	input  inst_word_u         inst_word,
	input  logic [`TAG_W-1:0]  dest_tag,
	input  logic [`TAG_W-1:0]  src1_tag,
	input  logic               src1_ready,
	input  logic [`DATA_W-1:0] src1_value,
	input  logic [`TAG_W-1:0]  src2_tag,
	input  logic               src2_ready,
	input  logic [`DATA_W-1:0] src2_value,
	output logic               cdb_valid,
	output logic [`TAG_W-1:0]  cdb_tag,
	output logic [`DATA_W-1:0] cdb_value,
	output logic               rs_full,
	output logic               dispatch_drop
);

	// Decode to station
	logic               dec_valid;
	fu_class_e          dec_class;
	alu_op_e            dec_op;
	logic [`TAG_W-1:0]  dec_dest;
	logic [`TAG_W-1:0]  dec_t1;
	logic [`TAG_W-1:0]  dec_t2;
	logic               dec_r1;
	logic               dec_r2;
	logic [`DATA_W-1:0] dec_v1;
	logic [`DATA_W-1:0] dec_v2;

	// Station to units
	logic               alu_issue;
	alu_op_e            alu_op;
	logic [`DATA_W-1:0] alu_a;
	logic [`DATA_W-1:0] alu_b;
	logic [`TAG_W-1:0]  alu_tag;
	logic               mul_issue;
	logic [`DATA_W-1:0] mul_a;
	logic [`DATA_W-1:0] mul_b;
	logic [`TAG_W-1:0]  mul_tag;

	// Units to result stage
	logic               alu_done;
	logic [`DATA_W-1:0] alu_result;
	logic [`TAG_W-1:0]  alu_rtag;
	logic               mul_done;
	logic [`DATA_W-1:0] mul_result;
	logic [`TAG_W-1:0]  mul_rtag;
	logic               alu_hold;

	inst_decode u_decode (
		.clock          (clock),
		.reset          (reset),
		.dispatch_valid (dispatch_valid),
		.inst_word      (inst_word),
		.dest_tag       (dest_tag),
		.src1_tag       (src1_tag),
		.src2_tag       (src2_tag),
		.src1_ready     (src1_ready),
		.src2_ready     (src2_ready),
		.src1_value     (src1_value),
		.src2_value     (src2_value),
		.dec_valid      (dec_valid),
		.dec_class      (dec_class),
		.dec_op         (dec_op),
		.dec_dest       (dec_dest),
		.dec_t1         (dec_t1),
		.dec_t2         (dec_t2),
		.dec_r1         (dec_r1),
		.dec_r2         (dec_r2),
		.dec_v1         (dec_v1),
		.dec_v2         (dec_v2)
	);

	rs_station u_station (
		.clock         (clock),
		.reset         (reset),
		.dec_valid     (dec_valid),
		.dec_class     (dec_class),
		.dec_op        (dec_op),
		.dec_dest      (dec_dest),
		.dec_t1        (dec_t1),
		.dec_t2        (dec_t2),
		.dec_r1        (dec_r1),
		.dec_r2        (dec_r2),
		.dec_v1        (dec_v1),
		.dec_v2        (dec_v2),
		.cdb_valid     (cdb_valid),
		.cdb_tag       (cdb_tag),
		.cdb_value     (cdb_value),
		.alu_hold      (alu_hold),
		.alu_issue     (alu_issue),
		.alu_op        (alu_op),
		.alu_a         (alu_a),
		.alu_b         (alu_b),
		.alu_tag       (alu_tag),
		.mul_issue     (mul_issue),
		.mul_a         (mul_a),
		.mul_b         (mul_b),
		.mul_tag       (mul_tag),
		.rs_full       (rs_full),
		.dispatch_drop (dispatch_drop)
	);

	fu_execute u_execute (
		.clock      (clock),
		.reset      (reset),
		.alu_issue  (alu_issue),
		.alu_op     (alu_op),
		.alu_a      (alu_a),
		.alu_b      (alu_b),
		.alu_tag    (alu_tag),
		.mul_issue  (mul_issue),
		.mul_a      (mul_a),
		.mul_b      (mul_b),
		.mul_tag    (mul_tag),
		.alu_done   (alu_done),
		.alu_result (alu_result),
		.alu_rtag   (alu_rtag),
		.mul_done   (mul_done),
		.mul_result (mul_result),
		.mul_rtag   (mul_rtag)
	);

	cdb_result u_result (
		.clock      (clock),
		.reset      (reset),
		.alu_done   (alu_done),
		.alu_result (alu_result),
		.alu_rtag   (alu_rtag),
		.mul_done   (mul_done),
		.mul_result (mul_result),
		.mul_rtag   (mul_rtag),
		.cdb_valid  (cdb_valid),
		.cdb_tag    (cdb_tag),
		.cdb_value  (cdb_value),
		.alu_hold   (alu_hold)
	);

endmodule

// File: verification/sched_core_tb.sv
// Scheduler core testbench
// Sweep, random, dependent chain, collision and overflow dispatch against a per-tag record
`include "sched_config.svh"

module sched_core_tb import sched_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int RESET_CYCLES = 8;
	localparam int N_SWEEP      = 14;
	localparam int N_RANDOM     = 16;
	localparam int N_CHAIN      = 6;
	localparam int N_COLLIDE    = 6;
	localparam int N_INSTR      = N_SWEEP + N_RANDOM + 1 + N_CHAIN + N_COLLIDE + `RS_SIZE + 1;
	// Worst case a dozen cycles per instruction, plus drain slack
	localparam int MAX_CYCLES   = RESET_CYCLES + N_INSTR * 12 + 100;
	localparam logic [`TAG_W-1:0] NEVER_TAG = '1;

	logic               clock;
	logic               reset;
	logic               dispatch_valid;
	inst_word_u         inst_word;
	logic [`TAG_W-1:0]  dest_tag;
	logic [`TAG_W-1:0]  src1_tag;
	logic               src1_ready;
	logic [`DATA_W-1:0] src1_value;
	logic [`TAG_W-1:0]  src2_tag;
	logic               src2_ready;
	logic [`DATA_W-1:0] src2_value;
	logic               cdb_valid;
	logic [`TAG_W-1:0]  cdb_tag;
	logic [`DATA_W-1:0] cdb_value;
	logic               rs_full;
	logic               dispatch_drop;

	// Reference record, one slot per tag
	logic [`DATA_W-1:0] exp_value   [2**`TAG_W];
	int                 bcast_count [2**`TAG_W];
	logic               live        [2**`TAG_W];
	logic               dropped     [2**`TAG_W];

	integer             seed;
	int                 next_tag;
	int                 cycle;
	int                 value_errors;
	int                 check_errors;
	logic               sent_valid;
	logic [`TAG_W-1:0]  sent_tag;

	sched_core_top DUT (.*);

	initial clock = 1'b0;
	always #10 clock = ~clock;

	// ------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------
	function automatic logic [`DATA_W-1:0] apply_op(input logic [2:0] op,
			input logic [`DATA_W-1:0] a, input logic [`DATA_W-1:0] b);
		case (op)
			`OP_ADD: return a + b;
			`OP_SUB: return a - b;
			`OP_AND: return a & b;
			`OP_OR:  return a | b;
			`OP_XOR: return a ^ b;
			`OP_SHL: return a << b[3:0];
			`OP_MUL: return a * b;
			default: return '0;
		endcase
	endfunction

	// True once every live, accepted tag has been on the bus
	function automatic logic all_drained();
		for (int t = 0; t < next_tag; t++) begin
			if (live[t] && !dropped[t] && bcast_count[t] == 0) begin
				return 1'b0;
			end
		end
		return 1'b1;
	endfunction

	// One dispatch on the next edge
	// dep puts source 1 on dep_tag, not ready
	task automatic drive_inst(input logic [3:0] opcode, input logic dep,
			input logic [`TAG_W-1:0] dep_tag, input logic [`DATA_W-1:0] a,
			input logic [`DATA_W-1:0] b, input logic expect_bcast);
		logic [`DATA_W-1:0] op_a;
		logic [`DATA_W-1:0] op_b;
		logic [`TAG_W-1:0]  tag;
		tag  = `TAG_W'(next_tag);
		op_a = dep ? exp_value[dep_tag] : a;
		// Immediate replaces source 2, sign extended from the low byte
		op_b = opcode[3] ? {{(`DATA_W-8){b[7]}}, b[7:0]} : b;
		exp_value[tag] = apply_op(opcode[2:0], op_a, op_b);
		live[tag]      = expect_bcast && (opcode[2:0] != 3'd7);
		next_tag++;
		@(posedge clock);
		dispatch_valid <= 1'b1;
		inst_word      <= opcode[3] ? {opcode, 4'h1, b[7:0]} : {opcode, 4'h1, 4'h2, 4'h3};
		dest_tag       <= tag;
		src1_tag       <= dep ? dep_tag : NEVER_TAG;
		src1_ready     <= !dep;
		src1_value     <= a;
		src2_tag       <= NEVER_TAG;
		src2_ready     <= 1'b1;
		src2_value     <= b;
	endtask

	task automatic drain();
		@(posedge clock);
		dispatch_valid <= 1'b0;
		while (!all_drained()) begin
			@(posedge clock);
		end
	endtask

	// Bus count, drop tracking, cycle count
	always @(posedge clock) begin
		cycle <= cycle + 1;
		if (cdb_valid) begin
			bcast_count[cdb_tag] <= bcast_count[cdb_tag] + 1;
		end
		// Drop pulse belongs to the tag decode took one edge earlier
		if (dispatch_drop && sent_valid) begin
			dropped[sent_tag] <= 1'b1;
		end
		sent_valid <= dispatch_valid;
		sent_tag   <= dest_tag;
	end

	always @(posedge clock) begin
		if (cycle >= MAX_CYCLES) begin
			$display("Run stopped after %0d cycles, results never drained", cycle);
			$display("Verification failed");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------
	a_value: assert property (@(posedge clock) disable iff (reset)
		cdb_valid |-> cdb_value == exp_value[cdb_tag])
	else begin
		value_errors++;
		$display("mismatch at %0t: tag %0d carries %h, expected %h", $time,
			$sampled(cdb_tag), $sampled(cdb_value), exp_value[$sampled(cdb_tag)]);
	end

	// Only live, accepted tags, and each of them once
	a_once: assert property (@(posedge clock) disable iff (reset)
		cdb_valid |-> live[cdb_tag] && !dropped[cdb_tag] && bcast_count[cdb_tag] == 0)
	else begin
		check_errors++;
		$display("Tag %0d was broadcast though dropped, parked or already sent, at %0t",
			$sampled(cdb_tag), $time);
	end

	// Quiet outputs during and right after reset
	a_reset_quiet: assert property (@(posedge clock)
		((reset && cycle > 0) || $fell(reset)) |-> !cdb_valid && !rs_full && !dispatch_drop)
	else begin
		check_errors++;
		$display("Bus, full or drop flag active around reset at %0t", $time);
	end

	// ------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------
	initial begin
		logic [3:0]        opcode;
		logic [`TAG_W-1:0] last_tag;
		seed         = 32'hf71b_09db;
		next_tag     = 0;
		cycle        = 0;
		value_errors = 0;
		check_errors = 0;
		sent_valid   = 1'b0;
		sent_tag     = '0;
		for (int t = 0; t < 2**`TAG_W; t++) begin
			exp_value[t]   = '0;
			bcast_count[t] = 0;
			live[t]        = 1'b0;
			dropped[t]     = 1'b0;
		end
		reset          = 1'b1;
		dispatch_valid = 1'b0;
		inst_word      = '0;
		dest_tag       = '0;
		src1_tag       = '0;
		src1_ready     = 1'b0;
		src1_value     = '0;
		src2_tag       = '0;
		src2_ready     = 1'b0;
		src2_value     = '0;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;

		// Every operation in register then immediate form
		for (int i = 0; i < N_SWEEP; i++) begin
			opcode = {1'(i / 7), 3'(i % 7)};
			drive_inst(opcode, 1'b0, NEVER_TAG, $random(seed), $random(seed), 1'b1);
		end
		for (int i = 0; i < N_RANDOM; i++) begin
			opcode = {1'($random(seed)), 3'($unsigned($random(seed)) % 7)};
			drive_inst(opcode, 1'b0, NEVER_TAG, $random(seed), $random(seed), 1'b1);
		end
		// Reserved code, never on the bus
		drive_inst(4'h7, 1'b0, NEVER_TAG, $random(seed), $random(seed), 1'b0);
		drain();

		// Dependent chain, back to back so each consumer is seated before its producer ends
		drive_inst(4'h0, 1'b0, NEVER_TAG, $random(seed), $random(seed), 1'b1);
		for (int i = 1; i < N_CHAIN; i++) begin
			opcode = {1'(i >> 1), (i % 2 == 1) ? `OP_MUL : 3'(i)};
			drive_inst(opcode, 1'b1, `TAG_W'(next_tag - 1), '0, $random(seed), 1'b1);
		end
		drain();

		// Multiply then ALU, results meet at the bus
		for (int i = 0; i < N_COLLIDE; i++) begin
			opcode = (i % 2 == 0) ? {1'b0, `OP_MUL} : {1'b0, 3'(i)};
			drive_inst(opcode, 1'b0, NEVER_TAG, $random(seed), $random(seed), 1'b1);
		end
		drain();

		// Park every row on a tag nobody produces, then overflow
		for (int i = 0; i < `RS_SIZE; i++) begin
			drive_inst(4'h0, 1'b1, NEVER_TAG, '0, $random(seed), 1'b0);
		end
		last_tag = `TAG_W'(next_tag);
		drive_inst(4'h0, 1'b1, NEVER_TAG, '0, $random(seed), 1'b0);
		@(posedge clock);
		dispatch_valid <= 1'b0;
		while (!dropped[last_tag]) begin
			@(posedge clock);
		end
		if (!rs_full) begin
			check_errors++;
			$display("Station not full with every row parked");
		end
		for (int t = 0; t < next_tag - 1; t++) begin
			if (dropped[t]) begin
				check_errors++;
				$display("Tag %0d dropped though a row was free", t);
			end
		end
		// Settle window for any stray broadcast
		repeat (10) @(posedge clock);

		for (int t = 0; t < next_tag; t++) begin
			if (live[t] && !dropped[t] && bcast_count[t] != 1) begin
				check_errors++;
				$display("Tag %0d broadcast %0d times instead of once", t, bcast_count[t]);
			end
		end
		$display("Errors: %0d value, %0d check", value_errors, check_errors);
		if (value_errors == 0 && check_errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// File: src.f
+incdir+include
source/sched_pkg.sv
source/inst_decode.sv
source/rs_wakeup_cam.sv
source/rs_station.sv
source/fu_execute.sv
source/cdb_result.sv
source/sched_core_top.sv
verification/sched_core_tb.sv

// File: Bender.yml
package:
  name: sched_core

export_include_dirs:
  - include

sources:
  - source/sched_pkg.sv
  - source/inst_decode.sv
  - source/rs_wakeup_cam.sv
  - source/rs_station.sv
  - source/fu_execute.sv
  - source/cdb_result.sv
  - source/sched_core_top.sv
  - target: test
    files:
      - verification/sched_core_tb.sv
